//--- ip_hdr_pkg.sv
package ip_hdr_pkg;

  // Fixed IPv4 header without options
  localparam int IP_HDR_BYTES = 20;
  localparam int IP_HDR_BITS  = IP_HDR_BYTES * 8;

  // Values required of every accepted header
  localparam logic [3:0] IP_VERSION_4 = 4'd4;
  localparam logic [3:0] IP_IHL_MIN   = 4'd5;  // Header length in 32-bit words

  // Fields in wire order, so the first byte on the wire is the top byte of the struct
  typedef struct packed {
    logic [3:0]  version;
    logic [3:0]  ihl;
    logic [5:0]  dscp;
    logic [1:0]  ecn;
    logic [15:0] total_length;     // Header plus payload in bytes
    logic [15:0] identification;
    logic [2:0]  flags;
    logic [12:0] fragment_offset;
    logic [7:0]  ttl;
    logic [7:0]  protocol;         // 17 for UDP
    logic [15:0] header_checksum;  // Ones' complement over the header words
    logic [31:0] source_ip;
    logic [31:0] dest_ip;
  } ip_hdr_t;

endpackage

//--- byte_stream_pkg.sv
package byte_stream_pkg;

  // One beat of a byte stream
  // Last marks the final byte of a packet
  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } byte_beat_t;

endpackage

//--- sync_fifo.sv
module sync_fifo #(
  parameter int  DEPTH = 2,
  parameter type T     = logic [7:0]
) (
  input  logic i_clk,
  input  logic i_rst_n,
  input  logic i_wr_valid,
  output logic o_wr_ready,
  input  T     i_wr_data,
  output logic o_rd_valid,
  input  logic i_rd_ready,
  output T     o_rd_data
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  T              mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          full;
  logic          wr_fire;
  logic          rd_fire;

  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
    logic [AW-1:0] nxt;
    if (ptr == AW'(DEPTH - 1)) begin
      nxt = '0;  // Wrap around
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign full       = (count == CW'(DEPTH));
  assign o_rd_valid = (count != '0);
  assign o_wr_ready = !full || i_rd_ready;  // A read frees a slot this cycle
  assign o_rd_data  = mem[rd_ptr];

  assign wr_fire = i_wr_valid && o_wr_ready;
  assign rd_fire = o_rd_valid && i_rd_ready;

  always_ff @(posedge i_clk) begin
    if (wr_fire) begin
      mem[wr_ptr] <= i_wr_data;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_fire) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (rd_fire) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({wr_fire, rd_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_count_bound: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    count <= CW'(DEPTH));

  // Head entry must not move under a stalled reader
  a_rd_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_rd_valid && !i_rd_ready |=> o_rd_valid && $stable(o_rd_data));

endmodule

//--- ip_rx_header_parser.sv
module ip_rx_header_parser (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  logic                        i_in_valid,
  output logic                        o_in_ready,
  input  byte_stream_pkg::byte_beat_t i_in,
  output logic                        o_hdr_valid,
  input  logic                        i_hdr_ready,
  output ip_hdr_pkg::ip_hdr_t         o_hdr,
  output logic                        o_pay_valid,
  input  logic                        i_pay_ready,
  output byte_stream_pkg::byte_beat_t o_pay,
  output logic [15:0]                 o_drop_count
);

  import ip_hdr_pkg::*;

  typedef enum logic [1:0] {
    S_HDR,   // Collecting header bytes
    S_PUSH,  // Offering the header to the FIFO
    S_PAY,   // Forwarding payload
    S_DROP   // Discarding until last
  } state_t;

  state_t      state;
  logic [4:0]  byte_cnt;
  logic [15:0] csum;
  ip_hdr_t     hdr_q;
  ip_hdr_t     hdr_next;
  logic [16:0] csum_add;
  logic [15:0] csum_next;
  logic        in_fire;
  logic        hdr_done;
  logic        hdr_ok;

  assign in_fire  = i_in_valid && o_in_ready;
  assign hdr_done = (byte_cnt == 5'(IP_HDR_BYTES - 1));

  // New byte enters at the bottom of the header
  assign hdr_next = {hdr_q[IP_HDR_BITS-9:0], i_in.data};

  // Odd byte completes a word with the byte before it
  assign csum_add = {1'b0, csum} + {1'b0, hdr_q[7:0], i_in.data};

  always_comb begin
    if (byte_cnt[0]) begin
      csum_next = csum_add[15:0] + {15'd0, csum_add[16]};  // End-around carry
    end else begin
      csum_next = csum;
    end
  end

  // A valid header sums to all ones including its own checksum field
  assign hdr_ok = (hdr_next.version == IP_VERSION_4) &&
                  (hdr_next.ihl == IP_IHL_MIN) &&
                  (csum_next == 16'hFFFF);

  assign o_in_ready  = (state == S_HDR) || (state == S_DROP) ||
                       ((state == S_PAY) && i_pay_ready);
  assign o_hdr_valid = (state == S_PUSH);
  assign o_hdr       = hdr_q;
  assign o_pay_valid = (state == S_PAY) && i_in_valid;
  assign o_pay       = i_in;

  always_ff @(posedge i_clk) begin
    if ((state == S_HDR) && in_fire) begin
      hdr_q <= hdr_next;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state        <= S_HDR;
      byte_cnt     <= '0;
      csum         <= '0;
      o_drop_count <= '0;
    end else begin
      case (state)
        S_HDR: begin
          if (in_fire) begin
            if (i_in.last || hdr_done) begin
              byte_cnt <= '0;
              csum     <= '0;
              if (!i_in.last && hdr_ok) begin
                state <= S_PUSH;
              end else begin
                o_drop_count <= o_drop_count + 16'd1;
                if (!i_in.last) begin
                  state <= S_DROP;  // Rest of the packet still to come
                end
              end
            end else begin
              byte_cnt <= byte_cnt + 5'd1;
              csum     <= csum_next;
            end
          end
        end
        S_PUSH: begin
          if (i_hdr_ready) begin
            state <= S_PAY;
          end
        end
        S_PAY: begin
          if (in_fire && i_in.last) begin
            state <= S_HDR;
          end
        end
        S_DROP: begin
          if (in_fire && i_in.last) begin
            state <= S_HDR;
          end
        end
        default: begin
          state <= S_HDR;
        end
      endcase
    end
  end

  // Only headers that passed the checks reach the FIFO
  a_hdr_version: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_hdr_valid |-> (o_hdr.version == IP_VERSION_4) && (o_hdr.ihl == IP_IHL_MIN));

  a_hdr_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_hdr_valid && !i_hdr_ready |=> o_hdr_valid && $stable(o_hdr));

endmodule

//--- ip_rx_adapter.sv
module ip_rx_adapter (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  logic                        i_enable,
  input  logic                        i_hdr_valid,
  output logic                        o_hdr_ready,
  input  ip_hdr_pkg::ip_hdr_t         i_hdr,
  input  logic                        i_pay_valid,
  output logic                        o_pay_ready,
  input  byte_stream_pkg::byte_beat_t i_pay,
  output logic                        o_out_valid,
  input  logic                        i_out_ready,
  output byte_stream_pkg::byte_beat_t o_out
);

  import ip_hdr_pkg::*;
  import byte_stream_pkg::*;

  typedef enum logic [1:0] {
    ST_HDR,        // Waiting for a parsed header
    ST_WRITE_HDR,  // Emitting header bytes
    ST_PAYLOAD     // Passing payload through
  } state_t;

  state_t     state;
  logic [4:0] offset;
  ip_hdr_t    hdr_q;
  logic [7:0] hdr_byte;
  logic       hdr_fire;

  assign hdr_fire = i_hdr_valid && o_hdr_ready;

  // Byte number offset counted from the top of the struct
  always_comb begin
    hdr_byte = hdr_q[8 * (IP_HDR_BYTES - 1 - int'(offset)) +: 8];
  end

  always_comb begin
    if (state == ST_WRITE_HDR) begin
      o_out = byte_beat_t'{data: hdr_byte, last: 1'b0};
    end else begin
      o_out = i_pay;  // Keeps the payload last flag
    end
  end

  assign o_hdr_ready = (state == ST_HDR) && i_enable;
  assign o_out_valid = (state == ST_WRITE_HDR) ||
                       ((state == ST_PAYLOAD) && i_pay_valid);
  assign o_pay_ready = (state == ST_PAYLOAD) && i_out_ready;

  always_ff @(posedge i_clk) begin
    if (hdr_fire) begin
      hdr_q <= i_hdr;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state  <= ST_HDR;
      offset <= '0;
    end else if (!i_enable) begin
      state  <= ST_HDR;
      offset <= '0;
    end else begin
      case (state)
        ST_HDR: begin
          if (hdr_fire) begin
            offset <= '0;
            state  <= ST_WRITE_HDR;
          end
        end
        ST_WRITE_HDR: begin
          if (i_out_ready) begin
            if (offset == 5'(IP_HDR_BYTES - 1)) begin
              offset <= '0;
              state  <= ST_PAYLOAD;
            end else begin
              offset <= offset + 5'd1;
            end
          end
        end
        ST_PAYLOAD: begin
          if (i_pay_valid && i_out_ready && i_pay.last) begin
            state <= ST_HDR;
          end
        end
        default: begin
          state <= ST_HDR;
        end
      endcase
    end
  end

  a_offset_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    offset < 5'(IP_HDR_BYTES));

  // Nothing leaves between packets
  a_idle_quiet: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (state == ST_HDR) |-> !o_out_valid);

endmodule

//--- ros2_ip_rx.sv
module ros2_ip_rx #(
  parameter int HDR_FIFO_DEPTH = 2,
  parameter int OUT_FIFO_DEPTH = 32
) (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  logic                        i_enable,
  input  logic                        i_in_valid,
  output logic                        o_in_ready,
  input  byte_stream_pkg::byte_beat_t i_in,
  output logic                        o_out_valid,
  input  logic                        i_out_ready,
  output byte_stream_pkg::byte_beat_t o_out,
  output logic [15:0]                 o_drop_count
);

  import ip_hdr_pkg::*;
  import byte_stream_pkg::*;

  logic       hdr_push_valid;
  logic       hdr_push_ready;
  ip_hdr_t    hdr_push;
  logic       hdr_pop_valid;
  logic       hdr_pop_ready;
  ip_hdr_t    hdr_pop;
  logic       pay_valid;
  logic       pay_ready;
  byte_beat_t pay;
  logic       ad_out_valid;
  logic       ad_out_ready;
  byte_beat_t ad_out;

  ip_rx_header_parser parser_i (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_in_valid   (i_in_valid),
    .o_in_ready   (o_in_ready),
    .i_in         (i_in),
    .o_hdr_valid  (hdr_push_valid),
    .i_hdr_ready  (hdr_push_ready),
    .o_hdr        (hdr_push),
    .o_pay_valid  (pay_valid),
    .i_pay_ready  (pay_ready),
    .o_pay        (pay),
    .o_drop_count (o_drop_count)
  );

  sync_fifo #(
    .DEPTH (HDR_FIFO_DEPTH),
    .T     (ip_hdr_t)
  ) hdr_fifo_i (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_wr_valid (hdr_push_valid),
    .o_wr_ready (hdr_push_ready),
    .i_wr_data  (hdr_push),
    .o_rd_valid (hdr_pop_valid),
    .i_rd_ready (hdr_pop_ready),
    .o_rd_data  (hdr_pop)
  );

  ip_rx_adapter adapter_i (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_enable    (i_enable),
    .i_hdr_valid (hdr_pop_valid),
    .o_hdr_ready (hdr_pop_ready),
    .i_hdr       (hdr_pop),
    .i_pay_valid (pay_valid),
    .o_pay_ready (pay_ready),
    .i_pay       (pay),
    .o_out_valid (ad_out_valid),
    .i_out_ready (ad_out_ready),
    .o_out       (ad_out)
  );

  // Buffer toward the ROS2 message layer
  sync_fifo #(
    .DEPTH (OUT_FIFO_DEPTH),
    .T     (byte_beat_t)
  ) out_fifo_i (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_wr_valid (ad_out_valid),
    .o_wr_ready (ad_out_ready),
    .i_wr_data  (ad_out),
    .o_rd_valid (o_out_valid),
    .i_rd_ready (i_out_ready),
    .o_rd_data  (o_out)
  );

endmodule

//--- tb_clk_gen.sv
module tb_clk_gen #(
  parameter int PERIOD     = 10,
  parameter int RST_CYCLES = 16
) (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD / 2) o_clk = ~o_clk;
  end

  initial begin
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    o_rst_n <= 1'b1;  // Release on a rising edge
  end

endmodule

//--- tb_ros2_ip_rx.sv
module tb_ros2_ip_rx;

  import ip_hdr_pkg::*;
  import byte_stream_pkg::*;

  localparam int TIMEOUT_CYCLES = 20000;  // About ten times the length of all tests
  localparam int IDLE_CYCLES    = 40;     // Quiet time that exposes extra output beats
  localparam int OUT_DEPTH      = 32;
  localparam int READY_HIGH     = 0;
  localparam int READY_LOW      = 1;
  localparam int READY_RANDOM   = 2;

  logic        i_clk;
  logic        rst_n;
  logic        i_enable;
  logic        i_in_valid;
  logic        o_in_ready;
  byte_beat_t  i_in;
  logic        o_out_valid;
  logic        i_out_ready;
  byte_beat_t  o_out;
  logic [15:0] o_drop_count;

  byte_beat_t tx_q[$];
  byte_beat_t exp_q[$];
  byte_beat_t rx_q[$];
  integer     seed = 45;
  int         ready_mode = READY_HIGH;
  int         tx_total = 0;
  int         sent_beats = 0;
  int         pkt_id = 0;
  int         err_count = 0;
  int         pass_count = 0;
  int         fail_count = 0;
  int         cycle_count = 0;

  tb_clk_gen clk_gen_i (
    .o_clk   (i_clk),
    .o_rst_n (rst_n)
  );

  ros2_ip_rx #(
    .OUT_FIFO_DEPTH (OUT_DEPTH)
  ) ros2_ip_rx_i (
    .i_clk        (i_clk),
    .i_rst_n      (rst_n),
    .i_enable     (i_enable),
    .i_in_valid   (i_in_valid),
    .o_in_ready   (o_in_ready),
    .i_in         (i_in),
    .o_out_valid  (o_out_valid),
    .i_out_ready  (i_out_ready),
    .o_out        (o_out),
    .o_drop_count (o_drop_count)
  );

  // Input driver, holds each beat until accepted
  initial begin : in_driver
    logic fire;
    i_in_valid = 1'b0;
    i_in       = '0;
    forever begin
      @(posedge i_clk);
      fire = i_in_valid && o_in_ready;
      if (fire) begin
        sent_beats++;
      end
      if (fire || !i_in_valid) begin
        if (tx_q.size() > 0) begin
          i_in       <= tx_q.pop_front();
          i_in_valid <= 1'b1;
        end else begin
          i_in_valid <= 1'b0;
        end
      end
    end
  end

  initial begin : out_ready_driver
    i_out_ready = 1'b1;
    forever begin
      @(posedge i_clk);
      case (ready_mode)
        READY_LOW:    i_out_ready <= 1'b0;
        READY_RANDOM: i_out_ready <= (($random(seed) & 3) != 0);  // Low one time in four
        default:      i_out_ready <= 1'b1;
      endcase
    end
  end

  always @(posedge i_clk) begin : collector
    if (o_out_valid && i_out_ready) begin
      rx_q.push_back(o_out);
    end
  end

  initial begin : watchdog
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge i_clk);
      cycle_count++;
    end
    $display("Run timed out after %0d cycles without finishing the tests", cycle_count);
    $display("Verification failed");
    $finish;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("** Error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
      err_count++;
    end
  endtask

  // Queues one packet for the driver, optionally also as expected output
  task automatic build_packet(input int pay_len, input logic [3:0] version,
                              input logic [3:0] ihl, input bit bad_csum,
                              input int cut_len, input bit expect_out);
    logic [7:0]  hdr [IP_HDR_BYTES];
    logic [31:0] sum;
    logic [15:0] csum;
    logic [15:0] total;
    int          n_bytes;
    byte_beat_t  beat;
    total   = 16'(IP_HDR_BYTES + pay_len);
    hdr[0]  = {version, ihl};
    hdr[1]  = 8'h00;
    hdr[2]  = total[15:8];
    hdr[3]  = total[7:0];
    hdr[4]  = 8'h12;
    hdr[5]  = 8'(pkt_id);
    hdr[6]  = 8'h40;  // Don't fragment
    hdr[7]  = 8'h00;
    hdr[8]  = 8'd64;
    hdr[9]  = 8'd17;
    hdr[10] = 8'h00;
    hdr[11] = 8'h00;
    hdr[12] = 8'hC0;
    hdr[13] = 8'hA8;
    hdr[14] = 8'h01;
    hdr[15] = 8'h0A;
    hdr[16] = 8'hC0;
    hdr[17] = 8'hA8;
    hdr[18] = 8'h01;
    hdr[19] = 8'h14;
    sum = '0;
    for (int k = 0; k < IP_HDR_BYTES; k += 2) begin
      sum += {16'h0000, hdr[k], hdr[k + 1]};
    end
    while (sum[31:16] != 16'h0000) begin
      sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
    end
    csum = ~sum[15:0];
    if (bad_csum) begin
      csum = csum ^ 16'h0100;
    end
    hdr[10] = csum[15:8];
    hdr[11] = csum[7:0];
    n_bytes = (cut_len > 0) ? cut_len : int'(total);
    for (int i = 0; i < n_bytes; i++) begin
      beat.data = (i < IP_HDR_BYTES) ? hdr[i] : 8'($random(seed));
      beat.last = (i == n_bytes - 1);
      tx_q.push_back(beat);
      if (expect_out) begin
        exp_q.push_back(beat);
      end
    end
    tx_total += n_bytes;
    pkt_id++;
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge i_clk);
  endtask

  task automatic wait_input_done();
    while (sent_beats < tx_total) @(posedge i_clk);
  endtask

  task automatic wait_output();
    while (rx_q.size() < exp_q.size()) @(posedge i_clk);
    idle(IDLE_CYCLES);
  endtask

  task automatic compare_output(input string name);
    int n;
    n = exp_q.size();
    check_value({name, " beat count"}, n, rx_q.size());
    for (int i = 0; i < n && i < rx_q.size(); i++) begin
      check_value($sformatf("%s byte %0d data", name, i), exp_q[i].data, rx_q[i].data);
      check_value($sformatf("%s byte %0d last", name, i), exp_q[i].last, rx_q[i].last);
    end
    exp_q.delete();
    rx_q.delete();
  endtask

  task automatic end_test(input string name, input int err_before);
    if (err_count == err_before) begin
      pass_count++;
      $display("PASS %s", name);
    end else begin
      fail_count++;
      $display("FAIL %s with %0d errors", name, err_count - err_before);
    end
  endtask

  task automatic single_packet_test();
    int err0;
    err0 = err_count;
    build_packet(8, IP_VERSION_4, IP_IHL_MIN, 1'b0, 0, 1'b1);
    wait_output();
    compare_output("single_packet");
    end_test("single_packet", err0);
  endtask

  task automatic back_to_back_test();
    int err0;
    err0 = err_count;
    build_packet(1, IP_VERSION_4, IP_IHL_MIN, 1'b0, 0, 1'b1);
    build_packet(13, IP_VERSION_4, IP_IHL_MIN, 1'b0, 0, 1'b1);
    build_packet(40, IP_VERSION_4, IP_IHL_MIN, 1'b0, 0, 1'b1);
    wait_output();
    compare_output("back_to_back");
    end_test("back_to_back", err0);
  endtask

  task automatic backpressure_test();
    int err0;
    int sent0;
    err0  = err_count;
    sent0 = sent_beats;
    ready_mode <= READY_LOW;
    build_packet(60, IP_VERSION_4, IP_IHL_MIN, 1'b0, 0, 1'b1);
    build_packet(5, IP_VERSION_4, IP_IHL_MIN, 1'b0, 0, 1'b1);
    build_packet(17, IP_VERSION_4, IP_IHL_MIN, 1'b0, 0, 1'b1);
    idle(120);  // Output FIFO fills, then the input stalls
    // Only the output FIFO holds bytes, one input byte per entry
    check_value("backpressure input stalled", sent0 + OUT_DEPTH, sent_beats);
    check_value("backpressure output waiting", 1, o_out_valid);
    ready_mode <= READY_RANDOM;
    while (rx_q.size() < exp_q.size()) @(posedge i_clk);
    ready_mode <= READY_HIGH;
    wait_output();
    compare_output("backpressure");
    end_test("backpressure", err0);
  endtask

  task automatic bad_header_test();
    int          err0;
    logic [15:0] drops0;
    err0   = err_count;
    drops0 = o_drop_count;
    build_packet(10, IP_VERSION_4, IP_IHL_MIN, 1'b1, 0, 1'b0);
    build_packet(6, 4'd6, IP_IHL_MIN, 1'b0, 0, 1'b0);
    build_packet(4, IP_VERSION_4, 4'd6, 1'b0, 0, 1'b0);
    while (o_drop_count != drops0 + 16'd3) @(posedge i_clk);
    wait_input_done();
    build_packet(9, IP_VERSION_4, IP_IHL_MIN, 1'b0, 0, 1'b1);
    wait_output();
    compare_output("bad_header");
    check_value("bad_header drop count", drops0 + 16'd3, o_drop_count);
    end_test("bad_header", err0);
  endtask

  task automatic enable_test();
    int err0;
    err0 = err_count;
    @(posedge i_clk);
    i_enable <= 1'b0;
    build_packet(11, IP_VERSION_4, IP_IHL_MIN, 1'b0, 0, 1'b1);
    idle(100);
    check_value("enable beats while disabled", 0, rx_q.size());
    @(posedge i_clk);
    i_enable <= 1'b1;
    wait_output();
    compare_output("enable");
    end_test("enable", err0);
  endtask

  task automatic short_packet_test();
    int          err0;
    logic [15:0] drops0;
    err0   = err_count;
    drops0 = o_drop_count;
    build_packet(8, IP_VERSION_4, IP_IHL_MIN, 1'b0, 10, 1'b0);  // Last on byte 10
    wait_input_done();
    idle(5);
    check_value("short_packet drop count", drops0 + 16'd1, o_drop_count);
    build_packet(5, IP_VERSION_4, IP_IHL_MIN, 1'b0, 0, 1'b1);
    wait_output();
    compare_output("short_packet");
    end_test("short_packet", err0);
  endtask

  initial begin : main
    i_enable = 1'b1;
    wait (rst_n === 1'b1);
    @(posedge i_clk);
    check_value("reset drop count", 0, o_drop_count);
    single_packet_test();
    back_to_back_test();
    backpressure_test();
    bad_header_test();
    enable_test();
    short_packet_test();
    $display("Tests finished: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0 && err_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- src.f
ip_hdr_pkg.sv
byte_stream_pkg.sv
sync_fifo.sv
ip_rx_header_parser.sv
ip_rx_adapter.sv
ros2_ip_rx.sv
tb_clk_gen.sv
tb_ros2_ip_rx.sv
